// File: hdl/vic_bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module vic_bus_arbiter (
   input wire logic       clk_dot4x,
   input wire logic       rst,
   vic_raster_if.user     rif,
   input wire logic       den_i,
   input wire logic [2:0] yscroll_i,
   output logic           ba_o,
   output logic           aec_o
);

   typedef enum logic [1:0] {
      BUS_CPU,
      BUS_WARN,
      BUS_VIC
   } bus_state_e;

   localparam logic [1:0] WARN_LAST = 2'(vic_timing_pkg::BA_WARN_CYCLES - 1);

   logic       allow_bad_q;
   logic       allow_bad_d;
   logic       badline_q;
   logic       in_window;
   logic       phi_low_start;
   logic       phi_high_end;
   logic       ba;
   bus_state_e state_q;
   // phi high phases already given to the cpu with ba low
   logic [1:0] warn_cnt_q;

   assign phi_low_start = ~rif.phi & (rif.phase_tick == 4'd0);
   assign phi_high_end  = rif.phi & rif.dot_strobe & (rif.phase_tick == 4'hF);

   // den anywhere on line 48 opens the badline range for this frame
   always_comb begin
      allow_bad_d = allow_bad_q;
      if (den_i && (rif.raster_line == vic_timing_pkg::BADLINE_FIRST)) begin
         allow_bad_d = 1'b1;
      end
      if (rif.raster_line == vic_timing_pkg::BADLINE_LAST + 9'd1) begin
         allow_bad_d = 1'b0;
      end
   end

   assign in_window = (rif.raster_line >= vic_timing_pkg::BADLINE_FIRST) &&
                      (rif.raster_line <= vic_timing_pkg::BADLINE_LAST);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_q <= 1'b0;
         badline_q   <= 1'b0;
      end else if (phi_low_start) begin
         allow_bad_q <= allow_bad_d;
         // line low bits must match the vertical scroll
         badline_q   <= allow_bad_d & in_window & (rif.raster_line[2:0] == yscroll_i);
      end
   end

   // ba stays low over the whole character fetch range of a badline
   assign ba = ~(badline_q &&
                 (rif.cycle_num >= vic_timing_pkg::BA_CYCLE_FIRST) &&
                 (rif.cycle_num <= vic_timing_pkg::BA_CYCLE_LAST));

   // cpu keeps its phi high phases for a few cycles after ba falls,
   // then the vic holds aec low until ba is released
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         state_q    <= BUS_CPU;
         warn_cnt_q <= '0;
      end else begin
         case (state_q)
            BUS_CPU: begin
               if (!ba) begin
                  state_q    <= BUS_WARN;
                  warn_cnt_q <= '0;
               end
            end
            BUS_WARN: begin
               if (ba) begin
                  state_q <= BUS_CPU;
               end else if (phi_high_end) begin
                  if (warn_cnt_q == WARN_LAST) begin
                     state_q <= BUS_VIC;
                  end else begin
                     warn_cnt_q <= warn_cnt_q + 2'd1;
                  end
               end
            end
            BUS_VIC: begin
               if (ba) begin
                  state_q <= BUS_CPU;
               end
            end
            default: state_q <= BUS_CPU;
         endcase
      end
   end

   assign ba_o  = ba;
   // aec follows phi unless the vic owns the bus
   assign aec_o = rif.phi & (state_q != BUS_VIC);

endmodule : vic_bus_arbiter

`default_nettype wire

// File: hdl/vic_raster_if.sv
`timescale 1ns/1ns
`default_nettype none

interface vic_raster_if;

   // phi clock as seen by the cpu
   logic       phi;
   // tick inside the current half-phase, 0 to 15
   logic [3:0] phase_tick;
   // last tick of each dot
   logic       dot_strobe;
   logic [9:0] raster_x;
   // 8 dots per cycle
   logic [6:0] cycle_num;
   logic [8:0] raster_line;
   // first tick of a new line
   logic       line_start;

   modport timer (
      output phi, phase_tick, dot_strobe, raster_x, cycle_num, raster_line, line_start
   );

   modport user (
      input phi, phase_tick, dot_strobe, raster_x, cycle_num, raster_line, line_start
   );

endinterface : vic_raster_if

`default_nettype wire

// File: hdl/vic_raster_timer.sv
`timescale 1ns/1ns
`default_nettype none

module vic_raster_timer (
   input wire logic                  clk_dot4x,
   input wire logic                  rst,
   input wire vic_timing_pkg::chip_e chip_i,
   vic_raster_if.timer               rif
);

   localparam int TICK_W = $clog2(vic_timing_pkg::TICKS_PER_PHI);

   // low until the first tick after reset
   logic              run_q;
   // position in the phi cycle, low half then high half
   logic [TICK_W-1:0] tick_q;
   logic [9:0]        raster_x_q;
   logic [8:0]        raster_line_q;
   logic              line_start_q;
   logic [9:0]        x_max;
   logic [8:0]        y_max;
   logic              dot_strobe;
   logic              line_end;

   // per chip line and frame limits
   always_comb begin
      case (chip_i)
         vic_timing_pkg::CHIP_6567R8: begin
            x_max = vic_timing_pkg::RASTER_X_MAX_R8;
            y_max = vic_timing_pkg::RASTER_Y_MAX_R8;
         end
         vic_timing_pkg::CHIP_6567R56A: begin
            x_max = vic_timing_pkg::RASTER_X_MAX_R56A;
            y_max = vic_timing_pkg::RASTER_Y_MAX_R56A;
         end
         default: begin
            x_max = vic_timing_pkg::RASTER_X_MAX_6569;
            y_max = vic_timing_pkg::RASTER_Y_MAX_6569;
         end
      endcase
   end

   // reset parks the ring on its last tick so the first
   // real tick starts a phi low phase at dot 0
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         run_q  <= 1'b0;
         tick_q <= TICK_W'(vic_timing_pkg::TICKS_PER_PHI - 1);
      end else begin
         run_q  <= 1'b1;
         tick_q <= tick_q + 1'b1;
      end
   end

   // a dot is four ticks, strobe on the last of them
   assign dot_strobe = run_q & (tick_q[1:0] == 2'b11);
   assign line_end   = dot_strobe & (raster_x_q == x_max);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x_q    <= '0;
         raster_line_q <= '0;
         line_start_q  <= 1'b0;
      end else begin
         line_start_q <= line_end;
         if (line_end) begin
            raster_x_q <= '0;
            // line and dot wrap on the same tick
            if (raster_line_q == y_max) begin
               raster_line_q <= '0;
            end else begin
               raster_line_q <= raster_line_q + 9'd1;
            end
         end else if (dot_strobe) begin
            raster_x_q <= raster_x_q + 10'd1;
         end
      end
   end

   // upper tick bit selects the phi high half
   assign rif.phi         = run_q & tick_q[TICK_W-1];
   assign rif.phase_tick  = tick_q[3:0];
   assign rif.dot_strobe  = dot_strobe;
   assign rif.raster_x    = raster_x_q;
   assign rif.cycle_num   = raster_x_q[9:3];
   assign rif.raster_line = raster_line_q;
   assign rif.line_start  = line_start_q;

endmodule : vic_raster_timer

`default_nettype wire

// File: hdl/vic_reg_pkg.sv
`default_nettype none

package vic_reg_pkg;

   // cpu visible register addresses
   typedef enum logic [5:0] {
      REG_CTRL1  = 6'h11,
      REG_RASTER = 6'h12,
      REG_IRQ    = 6'h19,
      REG_IRQ_EN = 6'h1A,
      REG_BORDER = 6'h20,
      REG_BG0    = 6'h21
   } reg_addr_e;

   // control register 1 layout
   localparam int CTRL1_YSCROLL_LSB = 0;
   localparam int CTRL1_YSCROLL_MSB = 2;
   localparam int CTRL1_RSEL_BIT    = 3;
   localparam int CTRL1_DEN_BIT     = 4;
   localparam int CTRL1_BMM_BIT     = 5;
   localparam int CTRL1_ECM_BIT     = 6;
   // top bit of the raster compare value
   localparam int CTRL1_RASTER8_BIT = 7;

   // interrupt register bits
   localparam int IRQ_RST_BIT = 0;
   localparam int IRQ_ANY_BIT = 7;

   // colour registers hold a 4 bit palette index
   localparam int COLOR_W = 4;

   // unused bits and unmapped addresses read back as ones
   localparam logic [7:0] UNUSED_READ = 8'hFF;

endpackage : vic_reg_pkg

`default_nettype wire

// File: hdl/vic_registers.sv
`timescale 1ns/1ns
`default_nettype none

module vic_registers (
   input wire logic                    clk_dot4x,
   input wire logic                    rst,
   vic_raster_if.user                  rif,
   input wire logic                    ce_i,
   input wire logic                    rw_i,
   input wire vic_reg_pkg::reg_addr_e  adi_i,
   input wire logic [7:0]              dbi_i,
   output logic [7:0]                  dbo_o,
   output logic                        den_o,
   output logic [2:0]                  yscroll_o,
   output logic                        irq_o
);

   localparam int CW = vic_reg_pkg::COLOR_W;

   // ctrl1 below the raster bit, which lives in the compare value
   logic [vic_reg_pkg::CTRL1_RASTER8_BIT-1:0] ctrl1_q;
   logic [8:0]    raster_cmp_q;
   logic          irq_en_q;
   logic [CW-1:0] border_q;
   logic [CW-1:0] bg0_q;
   // raster interrupt latch
   logic          irst_q;
   logic          irq_q;
   logic [7:0]    dbo_q;
   logic [7:0]    rd_data;
   logic          wr_strobe;

   // cpu write data is sampled once, late in its phi high phase
   assign wr_strobe = ~ce_i & ~rw_i & rif.phi &
                      (rif.phase_tick == 4'(vic_timing_pkg::PHASE_DAV));

   // control registers
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ctrl1_q      <= '0;
         raster_cmp_q <= '0;
         irq_en_q     <= 1'b0;
      end else if (wr_strobe) begin
         case (adi_i)
            vic_reg_pkg::REG_CTRL1: begin
               ctrl1_q         <= dbi_i[vic_reg_pkg::CTRL1_RASTER8_BIT-1:0];
               raster_cmp_q[8] <= dbi_i[vic_reg_pkg::CTRL1_RASTER8_BIT];
            end
            vic_reg_pkg::REG_RASTER: raster_cmp_q[7:0] <= dbi_i;
            vic_reg_pkg::REG_IRQ_EN: irq_en_q <= dbi_i[vic_reg_pkg::IRQ_RST_BIT];
            default: ;
         endcase
      end
   end

   // colour registers
   always_ff @(posedge clk_dot4x) begin
      if (wr_strobe && (adi_i == vic_reg_pkg::REG_BORDER)) begin
         border_q <= dbi_i[CW-1:0];
      end
      if (wr_strobe && (adi_i == vic_reg_pkg::REG_BG0)) begin
         bg0_q <= dbi_i[CW-1:0];
      end
   end

   // compare runs once per line, on the tick after the line starts
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst_q <= 1'b0;
         irq_q  <= 1'b0;
      end else begin
         if (rif.line_start && (rif.raster_line == raster_cmp_q)) begin
            irst_q <= 1'b1;
         end
         // writing a one acknowledges the raster interrupt
         if (wr_strobe && (adi_i == vic_reg_pkg::REG_IRQ) &&
             dbi_i[vic_reg_pkg::IRQ_RST_BIT]) begin
            irst_q <= 1'b0;
         end
         irq_q <= irst_q & irq_en_q;
      end
   end

   // read mux, raster bits come from the live counter
   always_comb begin
      rd_data = vic_reg_pkg::UNUSED_READ;
      case (adi_i)
         vic_reg_pkg::REG_CTRL1: begin
            rd_data[vic_reg_pkg::CTRL1_YSCROLL_MSB:vic_reg_pkg::CTRL1_YSCROLL_LSB] =
               ctrl1_q[vic_reg_pkg::CTRL1_YSCROLL_MSB:vic_reg_pkg::CTRL1_YSCROLL_LSB];
            rd_data[vic_reg_pkg::CTRL1_RSEL_BIT] = ctrl1_q[vic_reg_pkg::CTRL1_RSEL_BIT];
            rd_data[vic_reg_pkg::CTRL1_DEN_BIT]  = ctrl1_q[vic_reg_pkg::CTRL1_DEN_BIT];
            rd_data[vic_reg_pkg::CTRL1_BMM_BIT]  = ctrl1_q[vic_reg_pkg::CTRL1_BMM_BIT];
            rd_data[vic_reg_pkg::CTRL1_ECM_BIT]  = ctrl1_q[vic_reg_pkg::CTRL1_ECM_BIT];
            rd_data[vic_reg_pkg::CTRL1_RASTER8_BIT] = rif.raster_line[8];
         end
         vic_reg_pkg::REG_RASTER: rd_data = rif.raster_line[7:0];
         vic_reg_pkg::REG_IRQ: begin
            rd_data[vic_reg_pkg::IRQ_ANY_BIT] = irq_q;
            rd_data[vic_reg_pkg::IRQ_RST_BIT] = irst_q;
         end
         vic_reg_pkg::REG_IRQ_EN: rd_data[vic_reg_pkg::IRQ_RST_BIT] = irq_en_q;
         vic_reg_pkg::REG_BORDER: rd_data[CW-1:0] = border_q;
         vic_reg_pkg::REG_BG0:    rd_data[CW-1:0] = bg0_q;
         default: ;
      endcase
   end

   // data out follows the address one tick later while selected,
   // otherwise holds
   always_ff @(posedge clk_dot4x) begin
      if (!ce_i && rw_i) begin
         dbo_q <= rd_data;
      end
   end

   assign dbo_o     = dbo_q;
   assign den_o     = ctrl1_q[vic_reg_pkg::CTRL1_DEN_BIT];
   assign yscroll_o = ctrl1_q[vic_reg_pkg::CTRL1_YSCROLL_MSB:vic_reg_pkg::CTRL1_YSCROLL_LSB];
   assign irq_o     = irq_q;

endmodule : vic_registers

`default_nettype wire

// File: hdl/vic_timing_pkg.sv
`default_nettype none

package vic_timing_pkg;

   // chip variants, the unused code runs with 6569 limits
   typedef enum logic [1:0] {
      CHIP_6567R8   = 2'd0,
      CHIP_6567R56A = 2'd1,
      CHIP_6569     = 2'd2,
      CHIP_UNUSED   = 2'd3
   } chip_e;

   // last dot of a raster line
   // 520, 512 and 504 dots per line
   localparam logic [9:0] RASTER_X_MAX_R8   = 10'd519;
   localparam logic [9:0] RASTER_X_MAX_R56A = 10'd511;
   localparam logic [9:0] RASTER_X_MAX_6569 = 10'd503;

   // last line of a frame
   // 263, 262 and 312 lines per frame
   localparam logic [8:0] RASTER_Y_MAX_R8   = 9'd262;
   localparam logic [8:0] RASTER_Y_MAX_R56A = 9'd261;
   localparam logic [8:0] RASTER_Y_MAX_6569 = 9'd311;

   // dot4x ticks in one full phi cycle, each half is 16 ticks
   localparam int TICKS_PER_PHI = 32;

   // tick inside a half-phase where cpu write data is valid
   localparam int PHASE_DAV = 12;

   // lines on which a badline may happen
   localparam logic [8:0] BADLINE_FIRST = 9'd48;
   localparam logic [8:0] BADLINE_LAST  = 9'd247;

   // cycles where ba is held low for character fetches
   localparam logic [6:0] BA_CYCLE_FIRST = 7'd12;
   localparam logic [6:0] BA_CYCLE_LAST  = 7'd54;

   // phi high phases the cpu still gets after ba falls
   localparam int BA_WARN_CYCLES = 3;

endpackage : vic_timing_pkg

`default_nettype wire

// File: hdl/vic_top.sv
`timescale 1ns/1ns
`default_nettype none

module vic_top (
   input wire logic       clk_dot4x,
   input wire logic       rst,
   input wire logic [1:0] chip_i,
   input wire logic       ce_i,
   input wire logic       rw_i,
   input wire logic [5:0] adi_i,
   input wire logic [7:0] dbi_i,
   output logic [7:0]     dbo_o,
   output logic           irq_o,
   output logic           ba_o,
   output logic           aec_o,
   output logic           clk_phi_o,
   output logic [9:0]     raster_x_o,
   output logic [8:0]     raster_line_o
);

   vic_timing_pkg::chip_e  chip;
   vic_reg_pkg::reg_addr_e adi;
   // ctrl1 fields used by the badline logic
   logic                   den;
   logic [2:0]             yscroll;

   assign chip = vic_timing_pkg::chip_e'(chip_i);
   assign adi  = vic_reg_pkg::reg_addr_e'(adi_i);

   // shared timing and raster position
   vic_raster_if rif ();

   vic_raster_timer u_timer (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip_i    (chip),
      .rif       (rif.timer)
   );

   vic_bus_arbiter u_arbiter (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .rif       (rif.user),
      .den_i     (den),
      .yscroll_i (yscroll),
      .ba_o      (ba_o),
      .aec_o     (aec_o)
   );

   vic_registers u_regs (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .rif       (rif.user),
      .ce_i      (ce_i),
      .rw_i      (rw_i),
      .adi_i     (adi),
      .dbi_i     (dbi_i),
      .dbo_o     (dbo_o),
      .den_o     (den),
      .yscroll_o (yscroll),
      .irq_o     (irq_o)
   );

   assign clk_phi_o     = rif.phi;
   assign raster_x_o    = rif.raster_x;
   assign raster_line_o = rif.raster_line;

endmodule : vic_top

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the vic core testbench with verilator and run it
# exit status is nonzero when the build fails or the run ends in $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
   --top-module tb_vic_top -f vic_core.f -o vic_sim &&
./obj_dir/vic_sim ||
{ echo "vic core simulation did not complete cleanly"; exit 1; }

// File: sim/tb_vic_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vic_top;

   localparam int CLK_PERIOD  = 20;
   localparam int DRIVE_DELAY = 2;
   localparam int SEED        = 69257;
   // four dot4x ticks per pixel, eight pixels per phi cycle
   localparam int DOT_TICKS   = vic_timing_pkg::TICKS_PER_PHI / 8;
   localparam int HALF_PHI    = vic_timing_pkg::TICKS_PER_PHI / 2;
   localparam longint FRAME_TICKS_6569 = (longint'(vic_timing_pkg::RASTER_X_MAX_6569) + 1) *
      (longint'(vic_timing_pkg::RASTER_Y_MAX_6569) + 1) * DOT_TICKS;
   localparam longint FRAME_TICKS_R8 = (longint'(vic_timing_pkg::RASTER_X_MAX_R8) + 1) *
      (longint'(vic_timing_pkg::RASTER_Y_MAX_R8) + 1) * DOT_TICKS;
   // two 6569 frames and one 6567R8 frame plus margin
   localparam longint RUN_LIMIT_NS =
      (2 * FRAME_TICKS_6569 + FRAME_TICKS_R8) * CLK_PERIOD * 5 / 3;
   // what the current cpu read is compared against
   localparam int RD_NONE   = 0;
   localparam int RD_FIXED  = 1;
   localparam int RD_RASTER = 2;

   logic       clk_dot4x;
   logic       rst;
   logic [1:0] chip_i;
   logic       ce_i;
   logic       rw_i;
   logic [5:0] adi_i;
   logic [7:0] dbi_i;
   logic [7:0] dbo_o;
   logic       irq_o;
   logic       ba_o;
   logic       aec_o;
   logic       clk_phi_o;
   logic [9:0] raster_x_o;
   logic [8:0] raster_line_o;

   string      test_name = "reset";
   int         rd_mode = RD_NONE;
   logic [7:0] rd_expect = '0;
   // reference model state, ticks counts edges since reset release
   int         ticks;
   logic [8:0] exp_cmp;
   logic       exp_en;
   logic       exp_den;
   logic [2:0] exp_ysc;
   logic       exp_allow;
   logic       exp_latch;
   logic       exp_irq;

   vic_top dut0 (
      .clk_dot4x     (clk_dot4x),
      .rst           (rst),
      .chip_i        (chip_i),
      .ce_i          (ce_i),
      .rw_i          (rw_i),
      .adi_i         (adi_i),
      .dbi_i         (dbi_i),
      .dbo_o         (dbo_o),
      .irq_o         (irq_o),
      .ba_o          (ba_o),
      .aec_o         (aec_o),
      .clk_phi_o     (clk_phi_o),
      .raster_x_o    (raster_x_o),
      .raster_line_o (raster_line_o)
   );

   initial begin
      clk_dot4x = 1'b0;
      forever #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;
   end

   // line and frame limits of the selected chip
   function automatic int x_last();
      case (chip_i)
         vic_timing_pkg::CHIP_6567R8:   return int'(vic_timing_pkg::RASTER_X_MAX_R8);
         vic_timing_pkg::CHIP_6567R56A: return int'(vic_timing_pkg::RASTER_X_MAX_R56A);
         default:                       return int'(vic_timing_pkg::RASTER_X_MAX_6569);
      endcase
   endfunction

   function automatic int y_last();
      case (chip_i)
         vic_timing_pkg::CHIP_6567R8:   return int'(vic_timing_pkg::RASTER_Y_MAX_R8);
         vic_timing_pkg::CHIP_6567R56A: return int'(vic_timing_pkg::RASTER_Y_MAX_R56A);
         default:                       return int'(vic_timing_pkg::RASTER_Y_MAX_6569);
      endcase
   endfunction

   function automatic int dots_since_reset(input int t);
      return (t > 0) ? (t - 1) / DOT_TICKS : 0;
   endfunction

   // phi is low for the first half phase after reset
   function automatic logic phi_at(input int t);
      return (t > 0) && (((t - 1) % vic_timing_pkg::TICKS_PER_PHI) >= HALF_PHI);
   endfunction

   function automatic int x_at(input int t);
      return dots_since_reset(t) % (x_last() + 1);
   endfunction

   function automatic int line_at(input int t);
      return (dots_since_reset(t) / (x_last() + 1)) % (y_last() + 1);
   endfunction

   // first tick of a line that follows a wrap, not the line after reset
   function automatic logic wraps_into_line(input int t);
      return (t > 1) && (((t - 1) % (DOT_TICKS * (x_last() + 1))) == 0);
   endfunction

   // cpu data is taken on the DAV tick of the phi high half
   function automatic logic dav_tick(input int t);
      return (t > 0) &&
             (((t - 1) % vic_timing_pkg::TICKS_PER_PHI) == HALF_PHI + vic_timing_pkg::PHASE_DAV);
   endfunction

   function automatic logic badline_at(input int t);
      int line;
      line = line_at(t);
      return exp_allow && (line >= int'(vic_timing_pkg::BADLINE_FIRST)) &&
             (line <= int'(vic_timing_pkg::BADLINE_LAST)) && (line[2:0] == exp_ysc);
   endfunction

   function automatic logic ba_at(input int t);
      int cyc;
      cyc = x_at(t) / 8;
      return !(badline_at(t) && (cyc >= int'(vic_timing_pkg::BA_CYCLE_FIRST)) &&
               (cyc <= int'(vic_timing_pkg::BA_CYCLE_LAST)));
   endfunction

   // cpu keeps the first three phi high phases after ba falls
   function automatic logic aec_at(input int t);
      int cyc;
      cyc = x_at(t) / 8;
      return phi_at(t) && !(badline_at(t) &&
         (cyc >= int'(vic_timing_pkg::BA_CYCLE_FIRST) + vic_timing_pkg::BA_WARN_CYCLES) &&
         (cyc <= int'(vic_timing_pkg::BA_CYCLE_LAST)));
   endfunction

   // reference model, advanced on the same edges as the DUT
   always @(posedge clk_dot4x) begin
      if (rst) begin
         ticks     <= 0;
         exp_cmp   <= '0;
         exp_en    <= 1'b0;
         exp_den   <= 1'b0;
         exp_ysc   <= '0;
         exp_allow <= 1'b0;
         exp_latch <= 1'b0;
         exp_irq   <= 1'b0;
      end else begin
         ticks <= ticks + 1;
         if ((line_at(ticks) == int'(vic_timing_pkg::BADLINE_FIRST)) && exp_den) begin
            exp_allow <= 1'b1;
         end
         if (line_at(ticks) == int'(vic_timing_pkg::BADLINE_LAST) + 1) begin
            exp_allow <= 1'b0;
         end
         if (wraps_into_line(ticks) && (line_at(ticks) == int'(exp_cmp))) begin
            exp_latch <= 1'b1;
         end
         if (dav_tick(ticks) && !ce_i && !rw_i) begin
            case (adi_i)
               vic_reg_pkg::REG_CTRL1: begin
                  exp_ysc    <= dbi_i[2:0];
                  exp_den    <= dbi_i[vic_reg_pkg::CTRL1_DEN_BIT];
                  exp_cmp[8] <= dbi_i[vic_reg_pkg::CTRL1_RASTER8_BIT];
               end
               vic_reg_pkg::REG_RASTER: exp_cmp[7:0] <= dbi_i;
               vic_reg_pkg::REG_IRQ_EN: exp_en <= dbi_i[0];
               // acknowledge wins over a set on the same tick
               vic_reg_pkg::REG_IRQ:    if (dbi_i[vic_reg_pkg::IRQ_RST_BIT]) exp_latch <= 1'b0;
               default: ;
            endcase
         end
         exp_irq <= exp_latch & exp_en;
      end
   end

   task automatic report_mismatch(input string check, input int expected, input int actual);
      $display("FAIL %s (%s) expected %0h actual %0h", test_name, check, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", check);
   endtask

   // all checks sample on the falling edge, away from the drive edge
   a_phi: assert property (@(negedge clk_dot4x) disable iff (rst)
      clk_phi_o == phi_at(ticks))
      else report_mismatch("clk_phi", int'(phi_at(ticks)), int'(clk_phi_o));
   a_x: assert property (@(negedge clk_dot4x) disable iff (rst)
      int'(raster_x_o) == x_at(ticks))
      else report_mismatch("raster_x", x_at(ticks), int'(raster_x_o));
   a_line: assert property (@(negedge clk_dot4x) disable iff (rst)
      int'(raster_line_o) == line_at(ticks))
      else report_mismatch("raster_line", line_at(ticks), int'(raster_line_o));
   a_read: assert property (@(negedge clk_dot4x) disable iff (rst)
      (rd_mode == RD_FIXED) |-> (dbo_o == rd_expect))
      else report_mismatch("read data", int'(rd_expect), int'(dbo_o));
   // data out shows the raster line of the tick before
   a_read_raster: assert property (@(negedge clk_dot4x) disable iff (rst)
      (rd_mode == RD_RASTER) |-> (dbo_o == 8'(line_at(ticks - 1))))
      else report_mismatch("raster read", line_at(ticks - 1) % 256, int'(dbo_o));
   a_irq: assert property (@(negedge clk_dot4x) disable iff (rst)
      irq_o == exp_irq)
      else report_mismatch("irq", int'(exp_irq), int'(irq_o));
   a_ba: assert property (@(negedge clk_dot4x) disable iff (rst)
      ba_o == ba_at(ticks))
      else report_mismatch("ba", int'(ba_at(ticks)), int'(ba_o));
   a_aec: assert property (@(negedge clk_dot4x) disable iff (rst)
      aec_o == aec_at(ticks))
      else report_mismatch("aec", int'(aec_at(ticks)), int'(aec_o));
   a_aec_phi_low: assert property (@(negedge clk_dot4x) disable iff (rst)
      !clk_phi_o |-> !aec_o)
      else report_mismatch("aec while phi low", 0, int'(aec_o));

   initial begin
      #(RUN_LIMIT_NS);
      $display("Simulation FAILED");
      $fatal(1, "timeout, the tests did not finish within %0d ns", RUN_LIMIT_NS);
   end

   task automatic step();
      @(posedge clk_dot4x);
      #(DRIVE_DELAY);
   endtask

   task automatic apply_reset(input logic [1:0] chip);
      rst    = 1'b1;
      chip_i = chip;
      ce_i   = 1'b1;
      rw_i   = 1'b1;
      repeat (4) step();
      rst = 1'b0;
   endtask

   // one cpu access, ce held low across a whole phi high phase
   task automatic bus_cycle(input logic write, input logic [5:0] addr, input logic [7:0] data,
                            input int mode, input logic [7:0] expect_val);
      while (clk_phi_o) step();
      ce_i  = 1'b0;
      rw_i  = ~write;
      adi_i = addr;
      dbi_i = data;
      step();
      rd_expect = expect_val;
      rd_mode   = write ? RD_NONE : mode;
      while (!clk_phi_o) step();
      while (clk_phi_o) step();
      rd_mode = RD_NONE;
      ce_i    = 1'b1;
      rw_i    = 1'b1;
   endtask

   task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
      bus_cycle(1'b1, addr, data, RD_NONE, 8'h00);
   endtask

   task automatic bus_read(input logic [5:0] addr, input int mode, input logic [7:0] value);
      bus_cycle(1'b0, addr, 8'h00, mode, value);
   endtask

   task automatic wait_line(input int line);
      while (int'(raster_line_o) != line) step();
   endtask

   initial begin
      logic [7:0] border_val;
      logic [7:0] bg_val;
      logic [8:0] line_pick;
      void'($urandom(SEED));
      rst    = 1'b1;
      chip_i = 2'd0;
      ce_i   = 1'b1;
      rw_i   = 1'b1;
      adi_i  = '0;
      dbi_i  = '0;

      // 6567R8 without den and irq enable, colour and raster reads
      test_name = "r8_registers";
      apply_reset(vic_timing_pkg::CHIP_6567R8);
      border_val = 8'($urandom);
      bg_val     = 8'($urandom);
      line_pick  = 9'(40 + $urandom % 200);
      bus_write(vic_reg_pkg::REG_BORDER, border_val);
      bus_read(vic_reg_pkg::REG_BORDER, RD_FIXED, {4'hF, border_val[3:0]});
      bus_write(vic_reg_pkg::REG_BG0, bg_val);
      bus_read(vic_reg_pkg::REG_BG0, RD_FIXED, {4'hF, bg_val[3:0]});
      bus_read(vic_reg_pkg::REG_RASTER, RD_RASTER, 8'h00);
      bus_read(6'h3F, RD_FIXED, vic_reg_pkg::UNUSED_READ);
      // compare matches this frame but the enable stays clear
      bus_write(vic_reg_pkg::REG_RASTER, line_pick[7:0]);
      test_name = "r8_frame_wrap";
      wait_line(int'(vic_timing_pkg::RASTER_Y_MAX_R8));
      wait_line(0);

      // 6569 with den, yscroll 3 and the raster irq enabled
      test_name = "6569_irq_badline";
      apply_reset(vic_timing_pkg::CHIP_6569);
      line_pick = 9'(60 + $urandom % 240);
      bus_write(vic_reg_pkg::REG_RASTER, line_pick[7:0]);
      bus_write(vic_reg_pkg::REG_CTRL1, {line_pick[8], 7'h13});
      bus_write(vic_reg_pkg::REG_IRQ_EN, 8'h01);
      while (!irq_o) step();
      bus_write(vic_reg_pkg::REG_IRQ, 8'h01);
      test_name = "6569_next_frame";
      while (!irq_o) step();
      wait_line(int'(line_pick) + 1);

      $display("Simulation PASSED");
      $finish;
   end

endmodule : tb_vic_top

`default_nettype wire

// File: vic_core.f
hdl/vic_timing_pkg.sv
hdl/vic_reg_pkg.sv
hdl/vic_raster_if.sv
hdl/vic_raster_timer.sv
hdl/vic_bus_arbiter.sv
hdl/vic_registers.sv
hdl/vic_top.sv
sim/tb_vic_top.sv
